// ==== rtl/mpmem_defines.svh ====
`ifndef MPMEM_DEFINES_SVH
`define MPMEM_DEFINES_SVH

// ports per direction.
`define MPMEM_NUMPORT 4

// banks; the bank field sits in the high address bits.
`define MPMEM_NUMBANK 8
`define MPMEM_BITBANK 3
`define MPMEM_BITROW  6
`define MPMEM_BITADDR 9

`define MPMEM_WIDTH 32

// wishbone word offsets of the register block.
`define MPMEM_REG_CTRL   0
`define MPMEM_REG_STATUS 1
`define MPMEM_REG_WCNT   2
`define MPMEM_REG_RCNT   3

`endif

// ==== rtl/mpmem_pkg.sv ====
`include "mpmem_defines.svh"

package mpmem_pkg;

  // one write port request.
  typedef struct packed {
    logic                      valid;
    logic [`MPMEM_BITADDR-1:0] addr;
    logic [`MPMEM_WIDTH-1:0]   data;
  } wr_req_t;

  // one read port request.
  typedef struct packed {
    logic                      valid;
    logic [`MPMEM_BITADDR-1:0] addr;
  } rd_req_t;

  // answer to one read port; err marks a read that lost its bank.
  typedef struct packed {
    logic                    valid;
    logic                    err;
    logic [`MPMEM_WIDTH-1:0] data;
  } rd_rsp_t;

  // bit p is set when port p lost arbitration in this cycle.
  typedef struct packed {
    logic [`MPMEM_NUMPORT-1:0] mask;
  } conflict_t;

endpackage

// ==== rtl/bank_arbiter.sv ====
`timescale 1ns/10ps
`include "mpmem_defines.svh"

module bank_arbiter #(
  parameter type req_t = mpmem_pkg::rd_req_t
) (
  input  logic                 enable,
  input  req_t                 req   [`MPMEM_NUMPORT],
  output req_t                 grant [`MPMEM_NUMPORT],
  output mpmem_pkg::conflict_t lose
);

  logic [`MPMEM_NUMPORT-1:0] active;
  logic [`MPMEM_NUMPORT-1:0] shadowed;
  logic [`MPMEM_BITBANK-1:0] bank [`MPMEM_NUMPORT];

  // a disabled memory sees no requests at all.
  always_comb begin
    for (int p = 0; p < `MPMEM_NUMPORT; p++) begin
      active[p] = enable & req[p].valid;
      bank[p]   = req[p].addr[`MPMEM_BITADDR-1 -: `MPMEM_BITBANK];
    end
  end

  // a port is shadowed when any lower-numbered active port uses the same bank.
  always_comb begin
    shadowed = '0;
    for (int p = 1; p < `MPMEM_NUMPORT; p++) begin
      for (int q = 0; q < p; q++) begin
        if (active[q] && (bank[q] == bank[p])) begin
          shadowed[p] = 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int p = 0; p < `MPMEM_NUMPORT; p++) begin
      grant[p]       = req[p];
      grant[p].valid = active[p] & ~shadowed[p];
    end
    lose.mask = active & shadowed;
  end

endmodule

// ==== rtl/bank_sram.sv ====
`timescale 1ns/10ps
`include "mpmem_defines.svh"

module bank_sram (
  input  logic                     clk,
  input  logic                     we,
  input  logic [`MPMEM_BITROW-1:0] waddr,
  input  logic [`MPMEM_WIDTH-1:0]  wdata,
  input  logic                     re,
  input  logic [`MPMEM_BITROW-1:0] raddr,
  output logic [`MPMEM_WIDTH-1:0]  rdata
);

  logic [`MPMEM_WIDTH-1:0] mem [2**`MPMEM_BITROW];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // a read at the same edge as a write to that row sees the old word.
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= mem[raddr];
    end
  end

endmodule

// ==== rtl/bank_crossbar.sv ====
`timescale 1ns/10ps
`include "mpmem_defines.svh"

module bank_crossbar (
  input  logic                     clk,
  input  logic                     rst,
  input  mpmem_pkg::wr_req_t       wr_grant   [`MPMEM_NUMPORT],
  input  mpmem_pkg::rd_req_t       rd_grant   [`MPMEM_NUMPORT],
  input  mpmem_pkg::conflict_t     rd_lose,
  output logic                     bank_we    [`MPMEM_NUMBANK],
  output logic [`MPMEM_BITROW-1:0] bank_waddr [`MPMEM_NUMBANK],
  output logic [`MPMEM_WIDTH-1:0]  bank_wdata [`MPMEM_NUMBANK],
  output logic                     bank_re    [`MPMEM_NUMBANK],
  output logic [`MPMEM_BITROW-1:0] bank_raddr [`MPMEM_NUMBANK],
  input  logic [`MPMEM_WIDTH-1:0]  bank_rdata [`MPMEM_NUMBANK],
  output mpmem_pkg::rd_rsp_t       rd_rsp     [`MPMEM_NUMPORT]
);

  logic [`MPMEM_NUMPORT-1:0] rd_act_q;
  logic [`MPMEM_NUMPORT-1:0] rd_err_q;
  logic [`MPMEM_BITBANK-1:0] rd_bank_q [`MPMEM_NUMPORT];

  logic [`MPMEM_NUMPORT-1:0] rsp_valid_q;
  logic [`MPMEM_NUMPORT-1:0] rsp_err_q;
  logic [`MPMEM_WIDTH-1:0]   rsp_data_q [`MPMEM_NUMPORT];

  // granted requests never share a bank, so each bank takes at most one port.
  always_comb begin
    for (int b = 0; b < `MPMEM_NUMBANK; b++) begin
      bank_we[b]    = 1'b0;
      bank_waddr[b] = '0;
      bank_wdata[b] = '0;
      bank_re[b]    = 1'b0;
      bank_raddr[b] = '0;
      for (int p = 0; p < `MPMEM_NUMPORT; p++) begin
        if (wr_grant[p].valid &&
            (wr_grant[p].addr[`MPMEM_BITADDR-1 -: `MPMEM_BITBANK] == `MPMEM_BITBANK'(b))) begin
          bank_we[b]    = 1'b1;
          bank_waddr[b] = wr_grant[p].addr[`MPMEM_BITROW-1:0];
          bank_wdata[b] = wr_grant[p].data;
        end
        if (rd_grant[p].valid &&
            (rd_grant[p].addr[`MPMEM_BITADDR-1 -: `MPMEM_BITBANK] == `MPMEM_BITBANK'(b))) begin
          bank_re[b]    = 1'b1;
          bank_raddr[b] = rd_grant[p].addr[`MPMEM_BITROW-1:0];
        end
      end
    end
  end

  // first stage runs alongside the bank read.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_act_q <= '0;
      rd_err_q <= '0;
    end else begin
      for (int p = 0; p < `MPMEM_NUMPORT; p++) begin
        rd_act_q[p] <= rd_grant[p].valid;
        rd_err_q[p] <= rd_lose.mask[p];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < `MPMEM_NUMPORT; p++) begin
      rd_bank_q[p] <= rd_grant[p].addr[`MPMEM_BITADDR-1 -: `MPMEM_BITBANK];
    end
  end

  // second stage picks the bank word, or zero for a port that lost.
  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid_q <= '0;
      rsp_err_q   <= '0;
    end else begin
      rsp_valid_q <= rd_act_q | rd_err_q;
      rsp_err_q   <= rd_err_q;
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < `MPMEM_NUMPORT; p++) begin
      rsp_data_q[p] <= rd_act_q[p] ? bank_rdata[rd_bank_q[p]] : '0;
    end
  end

  always_comb begin
    for (int p = 0; p < `MPMEM_NUMPORT; p++) begin
      rd_rsp[p].valid = rsp_valid_q[p];
      rd_rsp[p].err   = rsp_err_q[p];
      rd_rsp[p].data  = rsp_data_q[p];
    end
  end

endmodule

// ==== rtl/mpmem_csr.sv ====
`timescale 1ns/10ps
`include "mpmem_defines.svh"

module mpmem_csr (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  logic [1:0]           wb_adr,
  input  logic [31:0]          wb_dat_w,
  output logic [31:0]          wb_dat_r,
  output logic                 wb_ack,
  output logic                 enable,
  input  mpmem_pkg::conflict_t wr_lose,
  input  mpmem_pkg::conflict_t rd_lose
);

  logic        access;
  logic        wr_ctrl;
  logic        wr_status;
  logic        wr_wcnt;
  logic        wr_rcnt;
  logic [7:0]  status;
  logic [15:0] wcnt;
  logic [15:0] rcnt;

  function automatic logic [2:0] popcount(input logic [`MPMEM_NUMPORT-1:0] mask);
    logic [2:0] n;
    n = '0;
    for (int i = 0; i < `MPMEM_NUMPORT; i++) begin
      n = n + 3'(mask[i]);
    end
    return n;
  endfunction

  // counters stick at all ones instead of wrapping.
  function automatic logic [15:0] sat_add(input logic [15:0] base, input logic [2:0] inc);
    logic [16:0] sum;
    sum = {1'b0, base} + 17'(inc);
    return sum[16] ? 16'hffff : sum[15:0];
  endfunction

  // a request is taken once; ack high blocks the next cycle from retaking it.
  assign access    = wb_cyc & wb_stb & ~wb_ack;
  assign wr_ctrl   = access & wb_we & (wb_adr == `MPMEM_REG_CTRL);
  assign wr_status = access & wb_we & (wb_adr == `MPMEM_REG_STATUS);
  assign wr_wcnt   = access & wb_we & (wb_adr == `MPMEM_REG_WCNT);
  assign wr_rcnt   = access & wb_we & (wb_adr == `MPMEM_REG_RCNT);

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
      enable <= 1'b0;
    end else begin
      wb_ack <= access;
      if (wr_ctrl) begin
        enable <= wb_dat_w[0];
      end
    end
  end

  // conflicts seen in a clearing cycle are still recorded.
  always_ff @(posedge clk) begin
    if (rst) begin
      status <= '0;
      wcnt   <= '0;
      rcnt   <= '0;
    end else begin
      status <= (status & ~(wr_status ? wb_dat_w[7:0] : 8'h00)) | {rd_lose.mask, wr_lose.mask};
      wcnt   <= sat_add(wr_wcnt ? 16'h0000 : wcnt, popcount(wr_lose.mask));
      rcnt   <= sat_add(wr_rcnt ? 16'h0000 : rcnt, popcount(rd_lose.mask));
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      case (wb_adr)
        2'(`MPMEM_REG_CTRL):   wb_dat_r <= {31'h0, enable};
        2'(`MPMEM_REG_STATUS): wb_dat_r <= {24'h0, status};
        2'(`MPMEM_REG_WCNT):   wb_dat_r <= {16'h0, wcnt};
        default:               wb_dat_r <= {16'h0, rcnt};
      endcase
    end
  end

endmodule

// ==== rtl/mpmem_top.sv ====
`timescale 1ns/10ps
`include "mpmem_defines.svh"

module mpmem_top (
  input  logic               clk,
  input  logic               rst,
  input  mpmem_pkg::wr_req_t wr     [`MPMEM_NUMPORT],
  input  mpmem_pkg::rd_req_t rd     [`MPMEM_NUMPORT],
  output mpmem_pkg::rd_rsp_t rd_rsp [`MPMEM_NUMPORT],
  input  logic               wb_cyc,
  input  logic               wb_stb,
  input  logic               wb_we,
  input  logic [1:0]         wb_adr,
  input  logic [31:0]        wb_dat_w,
  output logic [31:0]        wb_dat_r,
  output logic               wb_ack
);

  logic                     enable;
  mpmem_pkg::wr_req_t       wr_grant [`MPMEM_NUMPORT];
  mpmem_pkg::rd_req_t       rd_grant [`MPMEM_NUMPORT];
  mpmem_pkg::conflict_t     wr_lose;
  mpmem_pkg::conflict_t     rd_lose;

  logic                     bank_we    [`MPMEM_NUMBANK];
  logic [`MPMEM_BITROW-1:0] bank_waddr [`MPMEM_NUMBANK];
  logic [`MPMEM_WIDTH-1:0]  bank_wdata [`MPMEM_NUMBANK];
  logic                     bank_re    [`MPMEM_NUMBANK];
  logic [`MPMEM_BITROW-1:0] bank_raddr [`MPMEM_NUMBANK];
  logic [`MPMEM_WIDTH-1:0]  bank_rdata [`MPMEM_NUMBANK];

  bank_arbiter #(.req_t(mpmem_pkg::wr_req_t)) u_wr_arb (
    .enable (enable),
    .req    (wr),
    .grant  (wr_grant),
    .lose   (wr_lose)
  );

  bank_arbiter #(.req_t(mpmem_pkg::rd_req_t)) u_rd_arb (
    .enable (enable),
    .req    (rd),
    .grant  (rd_grant),
    .lose   (rd_lose)
  );

  bank_crossbar u_xbar (
    .clk        (clk),
    .rst        (rst),
    .wr_grant   (wr_grant),
    .rd_grant   (rd_grant),
    .rd_lose    (rd_lose),
    .bank_we    (bank_we),
    .bank_waddr (bank_waddr),
    .bank_wdata (bank_wdata),
    .bank_re    (bank_re),
    .bank_raddr (bank_raddr),
    .bank_rdata (bank_rdata),
    .rd_rsp     (rd_rsp)
  );

  for (genvar b = 0; b < `MPMEM_NUMBANK; b++) begin : g_bank
    bank_sram u_bank (
      .clk   (clk),
      .we    (bank_we[b]),
      .waddr (bank_waddr[b]),
      .wdata (bank_wdata[b]),
      .re    (bank_re[b]),
      .raddr (bank_raddr[b]),
      .rdata (bank_rdata[b])
    );
  end

  mpmem_csr u_csr (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .enable   (enable),
    .wr_lose  (wr_lose),
    .rd_lose  (rd_lose)
  );

endmodule

// ==== testbench/mpmem_checker.sv ====
`timescale 1ns/10ps
`include "mpmem_defines.svh"

module mpmem_checker (
  input logic               clk,
  input logic               rst,
  input mpmem_pkg::wr_req_t wr     [`MPMEM_NUMPORT],
  input mpmem_pkg::rd_req_t rd     [`MPMEM_NUMPORT],
  input mpmem_pkg::rd_rsp_t rd_rsp [`MPMEM_NUMPORT],
  input logic               wb_cyc,
  input logic               wb_stb,
  input logic               wb_we,
  input logic [1:0]         wb_adr,
  input logic [31:0]        wb_dat_w,
  input logic [31:0]        wb_dat_r,
  input logic               wb_ack
);

  localparam int NP = `MPMEM_NUMPORT;
  localparam int BB = `MPMEM_BITBANK;

  int                      errors;
  logic                    ref_en;
  logic                    ref_ack;
  logic                    ref_rd_pend;
  logic [31:0]             ref_rdat;
  logic [7:0]              ref_status;
  logic [15:0]             ref_wcnt;
  logic [15:0]             ref_rcnt;
  logic [`MPMEM_WIDTH-1:0] ref_mem   [2**`MPMEM_BITADDR];
  logic                    ref_known [2**`MPMEM_BITADDR];
  // stage 0 is the cycle just sampled; stage 1 is on rd_rsp now.
  mpmem_pkg::rd_rsp_t      exp_rsp   [2][NP];
  logic                    exp_known [2][NP];

  // a valid port loses to any lower-numbered valid port on the same bank.
  function automatic logic [NP-1:0] losers(input logic [NP-1:0] act, input logic [NP*BB-1:0] banks);
    logic [NP-1:0] m;
    m = '0;
    for (int p = 0; p < NP; p++) begin
      for (int q = 0; q < p; q++) begin
        if (act[p] && act[q] && (banks[q*BB +: BB] == banks[p*BB +: BB])) begin
          m[p] = 1'b1;
        end
      end
    end
    return m;
  endfunction

  function automatic logic [15:0] bump(input logic [15:0] cnt, input logic [NP-1:0] mask);
    int sum;
    sum = int'(cnt) + $countones(mask);
    return (sum > 65535) ? 16'hffff : 16'(sum);
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("mismatch at %0t ns: %s expected %h got %h", $time, name, exp, got);
    errors++;
  endtask

  initial begin
    errors = 0;
    for (int a = 0; a < 2**`MPMEM_BITADDR; a++) begin
      ref_known[a] = 1'b0;
    end
  end

  always @(posedge clk) begin : model
    logic [NP-1:0]    wact;
    logic [NP-1:0]    ract;
    logic [NP-1:0]    wlose;
    logic [NP-1:0]    rlose;
    logic [NP*BB-1:0] wbank;
    logic [NP*BB-1:0] rbank;
    logic             access;
    for (int p = 0; p < NP; p++) begin
      exp_rsp[1][p]   = exp_rsp[0][p];
      exp_known[1][p] = exp_known[0][p];
      exp_rsp[0][p]   = '0;
      exp_known[0][p] = 1'b1;
    end
    if (rst) begin
      ref_en      = 1'b0;
      ref_ack     = 1'b0;
      ref_rd_pend = 1'b0;
      ref_status  = '0;
      ref_wcnt    = '0;
      ref_rcnt    = '0;
    end else begin
      for (int p = 0; p < NP; p++) begin
        wact[p]           = ref_en & wr[p].valid;
        ract[p]           = ref_en & rd[p].valid;
        wbank[p*BB +: BB] = wr[p].addr[`MPMEM_BITADDR-1 -: BB];
        rbank[p*BB +: BB] = rd[p].addr[`MPMEM_BITADDR-1 -: BB];
      end
      wlose = losers(wact, wbank);
      rlose = losers(ract, rbank);
      // reads see the memory as it was before this edge's writes.
      for (int p = 0; p < NP; p++) begin
        exp_rsp[0][p].valid = ract[p];
        exp_rsp[0][p].err   = rlose[p];
        if (ract[p] && !rlose[p]) begin
          exp_rsp[0][p].data = ref_mem[rd[p].addr];
          exp_known[0][p]    = ref_known[rd[p].addr];
        end
      end
      for (int p = 0; p < NP; p++) begin
        if (wact[p] && !wlose[p]) begin
          ref_mem[wr[p].addr]   = wr[p].data;
          ref_known[wr[p].addr] = 1'b1;
        end
      end
      access      = wb_cyc & wb_stb & ~ref_ack;
      ref_rd_pend = access & ~wb_we;
      if (ref_rd_pend) begin
        case (wb_adr)
          2'(`MPMEM_REG_CTRL):   ref_rdat = {31'h0, ref_en};
          2'(`MPMEM_REG_STATUS): ref_rdat = {24'h0, ref_status};
          2'(`MPMEM_REG_WCNT):   ref_rdat = {16'h0, ref_wcnt};
          default:               ref_rdat = {16'h0, ref_rcnt};
        endcase
      end
      if (access && wb_we) begin
        case (wb_adr)
          2'(`MPMEM_REG_CTRL):   ref_en = wb_dat_w[0];
          2'(`MPMEM_REG_STATUS): ref_status = ref_status & ~wb_dat_w[7:0];
          2'(`MPMEM_REG_WCNT):   ref_wcnt = '0;
          default:               ref_rcnt = '0;
        endcase
      end
      ref_status = ref_status | {rlose, wlose};
      ref_wcnt   = bump(ref_wcnt, wlose);
      ref_rcnt   = bump(ref_rcnt, rlose);
      ref_ack    = access;
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      for (int p = 0; p < NP; p++) begin
        if (rd_rsp[p].valid !== exp_rsp[1][p].valid) begin
          report_mismatch($sformatf("rd_rsp[%0d].valid", p), 32'(exp_rsp[1][p].valid),
                          32'(rd_rsp[p].valid));
        end else if (exp_rsp[1][p].valid) begin
          if (rd_rsp[p].err !== exp_rsp[1][p].err) begin
            report_mismatch($sformatf("rd_rsp[%0d].err", p), 32'(exp_rsp[1][p].err),
                            32'(rd_rsp[p].err));
          end
          if (exp_known[1][p] && (rd_rsp[p].data !== exp_rsp[1][p].data)) begin
            report_mismatch($sformatf("rd_rsp[%0d].data", p), exp_rsp[1][p].data,
                            rd_rsp[p].data);
          end
        end
      end
      if (wb_ack !== ref_ack) begin
        report_mismatch("wb_ack", 32'(ref_ack), 32'(wb_ack));
      end else if (ref_ack && ref_rd_pend && (wb_dat_r !== ref_rdat)) begin
        report_mismatch("wb_dat_r", ref_rdat, wb_dat_r);
      end
    end
  end

endmodule

// ==== testbench/tb_mpmem.sv ====
`timescale 1ns/10ps
`include "mpmem_defines.svh"

module tb_mpmem;

  logic               clk;
  logic               rst;
  mpmem_pkg::wr_req_t wr     [`MPMEM_NUMPORT];
  mpmem_pkg::rd_req_t rd     [`MPMEM_NUMPORT];
  mpmem_pkg::rd_rsp_t rd_rsp [`MPMEM_NUMPORT];
  logic               wb_cyc;
  logic               wb_stb;
  logic               wb_we;
  logic [1:0]         wb_adr;
  logic [31:0]        wb_dat_w;
  logic [31:0]        wb_dat_r;
  logic               wb_ack;
  int                 seed;
  int                 tb_errors;
  logic [31:0]        rdat;

  mpmem_top UUT (
    .clk      (clk),
    .rst      (rst),
    .wr       (wr),
    .rd       (rd),
    .rd_rsp   (rd_rsp),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  mpmem_checker u_checker (
    .clk      (clk),
    .rst      (rst),
    .wr       (wr),
    .rd       (rd),
    .rd_rsp   (rd_rsp),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  always #5 clk = ~clk;

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic idle_ports();
    for (int p = 0; p < `MPMEM_NUMPORT; p++) begin
      wr[p] = '0;
      rd[p] = '0;
    end
  endtask

  task automatic write_port(input int p, input logic [8:0] addr, input logic [31:0] data);
    wr[p].valid = 1'b1;
    wr[p].addr  = addr;
    wr[p].data  = data;
  endtask

  task automatic read_port(input int p, input logic [8:0] addr);
    rd[p].valid = 1'b1;
    rd[p].addr  = addr;
  endtask

  // only four rows per bank, so ports collide often.
  task automatic random_ports();
    for (int p = 0; p < `MPMEM_NUMPORT; p++) begin
      wr[p].valid = 1'($random(seed));
      wr[p].addr  = {3'($random(seed)), 4'h0, 2'($random(seed))};
      wr[p].data  = $random(seed);
      rd[p].valid = 1'($random(seed));
      rd[p].addr  = {3'($random(seed)), 4'h0, 2'($random(seed))};
    end
  endtask

  task automatic bus_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                            output logic [31:0] data);
    int n;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    n = 0;
    do begin
      next_cycle();
      n++;
    end while (!wb_ack && (n < 20));
    if (!wb_ack) begin
      $display("no wishbone ack for register %0d within 20 cycles", adr);
      tb_errors++;
    end
    data   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    next_cycle();
  endtask

  task automatic expect_reg(input logic [1:0] adr, input logic [31:0] exp, input string name);
    logic [31:0] got;
    bus_access(1'b0, adr, 32'h0, got);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s expected %h got %h", $time, name, exp, got);
      tb_errors++;
    end
  endtask

  initial begin : stimulus
    clk       = 1'b0;
    rst       = 1'b1;
    seed      = 7816;
    tb_errors = 0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    idle_ports();
    repeat (3) next_cycle();
    rst = 1'b0;

    // the memory is still disabled, so none of this traffic counts.
    for (int i = 0; i < 6; i++) begin
      random_ports();
      next_cycle();
    end
    idle_ports();
    repeat (3) next_cycle();
    expect_reg(`MPMEM_REG_CTRL, 32'h0, "CTRL");
    expect_reg(`MPMEM_REG_STATUS, 32'h0, "STATUS");
    expect_reg(`MPMEM_REG_WCNT, 32'h0, "WCNT");
    expect_reg(`MPMEM_REG_RCNT, 32'h0, "RCNT");

    bus_access(1'b1, `MPMEM_REG_CTRL, 32'h1, rdat);
    expect_reg(`MPMEM_REG_CTRL, 32'h1, "CTRL");
    for (int i = 0; i < 8; i++) begin
      for (int p = 0; p < `MPMEM_NUMPORT; p++) begin
        write_port(p, {3'(2 * p + i % 2), 6'(i)}, $random(seed));
      end
      next_cycle();
    end
    idle_ports();
    for (int i = 0; i < 8; i++) begin
      for (int p = 0; p < `MPMEM_NUMPORT; p++) begin
        read_port(p, {3'(2 * p + i % 2), 6'(i)});
      end
      next_cycle();
    end
    idle_ports();
    repeat (3) next_cycle();

    // all write ports hit bank 3 together.
    for (int p = 0; p < `MPMEM_NUMPORT; p++) begin
      write_port(p, {3'd3, 6'd10}, 32'h3000_0000 + p);
    end
    next_cycle();
    idle_ports();
    read_port(0, {3'd3, 6'd10});
    next_cycle();
    idle_ports();
    repeat (3) next_cycle();
    expect_reg(`MPMEM_REG_WCNT, 32'h3, "WCNT");
    expect_reg(`MPMEM_REG_STATUS, 32'h0e, "STATUS");

    for (int p = 0; p < 3; p++) begin
      read_port(p, {3'd3, 6'd10});
    end
    read_port(3, {3'd0, 6'd0});
    next_cycle();
    idle_ports();
    repeat (3) next_cycle();
    expect_reg(`MPMEM_REG_RCNT, 32'h2, "RCNT");
    expect_reg(`MPMEM_REG_STATUS, 32'h6e, "STATUS");

    read_port(1, {3'd5, 6'd1});
    write_port(2, {3'd5, 6'd1}, 32'hcafe_f00d);
    next_cycle();
    idle_ports();
    read_port(1, {3'd5, 6'd1});
    next_cycle();
    idle_ports();
    repeat (3) next_cycle();

    bus_access(1'b1, `MPMEM_REG_STATUS, 32'hff, rdat);
    bus_access(1'b1, `MPMEM_REG_WCNT, 32'h0, rdat);
    bus_access(1'b1, `MPMEM_REG_RCNT, 32'h0, rdat);
    expect_reg(`MPMEM_REG_STATUS, 32'h0, "STATUS");
    expect_reg(`MPMEM_REG_WCNT, 32'h0, "WCNT");
    expect_reg(`MPMEM_REG_RCNT, 32'h0, "RCNT");
    for (int i = 0; i < 200; i++) begin
      random_ports();
      next_cycle();
    end
    idle_ports();
    repeat (3) next_cycle();
    bus_access(1'b0, `MPMEM_REG_STATUS, 32'h0, rdat);
    bus_access(1'b0, `MPMEM_REG_WCNT, 32'h0, rdat);
    bus_access(1'b0, `MPMEM_REG_RCNT, 32'h0, rdat);

    $display("errors: %0d in checker, %0d in testbench", u_checker.errors, tb_errors);
    if ((u_checker.errors == 0) && (tb_errors == 0)) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+rtl
rtl/mpmem_pkg.sv
rtl/bank_arbiter.sv
rtl/bank_sram.sv
rtl/bank_crossbar.sv
rtl/mpmem_csr.sv
rtl/mpmem_top.sv
testbench/mpmem_checker.sv
testbench/tb_mpmem.sv

// ==== Bender.yml ====
package:
  name: mpmem

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mpmem_pkg.sv
      - rtl/bank_arbiter.sv
      - rtl/bank_sram.sv
      - rtl/bank_crossbar.sv
      - rtl/mpmem_csr.sv
      - rtl/mpmem_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/mpmem_checker.sv
      - testbench/tb_mpmem.sv
